// ==== verilog.f ====
+incdir+verilog
+incdir+testbench
verilog/rv_pkg.sv
verilog/rv_control_unit.sv
verilog/rv_reg_file.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
testbench/rv_core_sva.sv
testbench/rv_core_tb.sv

// ==== testbench/rv_iss_model.svh ====
`ifndef RV_ISS_MODEL_SVH
`define RV_ISS_MODEL_SVH

// reference state, filled from the program image
logic [31:0]   refMem [256];
logic [31:0]   refReg [32];
rvPkg::retireT expQ [$];

function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic [31:0] m;
    m = 32'h1 << (bits - 1);
    return ((v & ((m << 1) - 32'h1)) ^ m) - m;
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000:  r = alt ? a - b : a + b;
        3'b001:  r = a << b[4:0];
        3'b010:  r = {31'h0, $signed(a) < $signed(b)};
        3'b011:  r = {31'h0, a < b};
        3'b100:  r = a ^ b;
        3'b101: begin
            if (alt)
                r = $signed(a) >>> b[4:0];
            else
                r = a >> b[4:0];
        end
        3'b110:  r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// runs the image until the zero word, one retire record per instruction
task automatic runModel();
    logic [31:0]   pc, ins, a, b, res, addr, word, nextPc;
    logic [2:0]    f3;
    logic          wr, taken;
    rvPkg::retireT rec;
    int            steps;
    refMem = mem;
    for (int r = 0; r < 32; r++) refReg[r] = 32'h0;
    pc = `RV_RESET_PC;
    steps = 0;
    ins = refMem[pc[9:2]];
    while (ins != 32'h0 && steps < 256) begin
        a = refReg[ins[19:15]];
        b = refReg[ins[24:20]];
        f3 = ins[14:12];
        nextPc = pc + 32'd4;
        wr = 1'b1;
        res = 32'h0;
        case (ins[6:0])
            `RV_OP_OP:     res = aluRef(f3, ins[30], a, b);
            `RV_OP_OP_IMM: res = aluRef(f3, ins[30] && f3 == 3'b101, a, sext(ins[31:20], 12));
            `RV_OP_LUI:    res = {ins[31:12], 12'h0};
            `RV_OP_AUIPC:  res = pc + {ins[31:12], 12'h0};
            `RV_OP_JAL: begin
                res = pc + 32'd4;
                nextPc = pc + sext({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
            end
            `RV_OP_JALR: begin
                res = pc + 32'd4;
                nextPc = (a + sext(ins[31:20], 12)) & ~32'h1;
            end
            `RV_OP_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nextPc = pc + sext({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
            end
            `RV_OP_LOAD: begin
                addr = a + sext(ins[31:20], 12);
                word = refMem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'b000:  res = sext(word, 8);
                    3'b001:  res = sext(word, 16);
                    3'b100:  res = word & 32'hFF;
                    3'b101:  res = word & 32'hFFFF;
                    default: res = word;
                endcase
            end
            default: begin
                // store
                wr = 1'b0;
                addr = a + sext({ins[31:25], ins[11:7]}, 12);
                for (int k = 0; k < (1 << f3[1:0]); k++)
                    refMem[addr[9:2]][8 * (addr[1:0] + k) +: 8] = b[8 * k +: 8];
            end
        endcase
        if (wr && ins[11:7] != 5'd0) refReg[ins[11:7]] = res;
        rec.pc = pc;
        rec.rd = wr ? ins[11:7] : 5'd0;
        rec.value = wr ? res : 32'h0;
        rec.regWrite = wr;
        expQ.push_back(rec);
        pc = nextPc;
        ins = refMem[pc[9:2]];
        steps++;
    end
endtask

`endif

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rvCoreTb;

    logic          clk, rst;
    logic          wbCyc, wbStb, wbWe, wbAck;
    logic [31:0]   wbAdr, wbDatW, wbDatR;
    logic [3:0]    wbSel;
    logic          retireValid, halted;
    rvPkg::retireT retire;

    logic [31:0] mem [256];
    integer      seed;
    int          retired, waitLeft;
    logic        busy, sawHalt;

    `include "rv_iss_model.svh"

    rv_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatW     (wbDatW),
        .wbSel      (wbSel),
        .wbDatR     (wbDatR),
        .wbAck      (wbAck),
        .retireValid(retireValid),
        .retire     (retire),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abortRun($sformatf("%s does not match the model", name));
        end
    endtask

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encR(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // 60 words of random code and then the zero word
    // x31 holds the data base 0x200
    task automatic buildProgram();
        int          i, tgt;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        bit          landing [61];
        for (int a = 0; a < 256; a++) mem[a] = (a * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
        for (int a = 0; a < 61; a++) landing[a] = 1'b0;
        mem[0] = encI(`RV_OP_OP_IMM, 3'b000, 5'd31, 5'd0, 12'h200);
        i = 1;
        while (i < 60) begin
            rd = 5'(1 + rnd(15));
            rs1 = 5'(rnd(16));
            rs2 = 5'(rnd(16));
            f3 = 3'(rnd(8));
            tgt = i + 1 + rnd(4);
            if (tgt > 60) tgt = 60;
            case (rnd(10))
                0, 1: mem[i] = encR(f3, ((f3 == 3'b000 || f3 == 3'b101) && rnd(2) == 1)
                                    ? 7'h20 : 7'h00, rd, rs1, rs2);
                2, 3: begin
                    if (f3 == 3'b001 || f3 == 3'b101)
                        imm = {(f3 == 3'b101 && rnd(2) == 1) ? 7'h20 : 7'h00, 5'(rnd(32))};
                    else
                        imm = 12'(rnd(4096));
                    mem[i] = encI(`RV_OP_OP_IMM, f3, rd, rs1, imm);
                end
                4: mem[i] = {20'($random(seed)), rd, (rnd(2) == 1) ? `RV_OP_LUI : `RV_OP_AUIPC};
                5: begin
                    case (rnd(5))
                        0: f3 = `RV_F3_B;
                        1: f3 = `RV_F3_H;
                        2: f3 = `RV_F3_W;
                        3: f3 = `RV_F3_BU;
                        default: f3 = `RV_F3_HU;
                    endcase
                    imm = 12'((rnd(256) >> f3[1:0]) << f3[1:0]);
                    mem[i] = encI(`RV_OP_LOAD, f3, rd, 5'd31, imm);
                end
                6: begin
                    f3 = 3'(rnd(3));
                    imm = 12'((rnd(256) >> f3[1:0]) << f3[1:0]);
                    mem[i] = encS(f3, 5'd31, rs2, imm);
                end
                7: begin
                    f3 = 3'(rnd(6));
                    if (f3 >= 3'd2) f3 = f3 + 3'd2;
                    mem[i] = encB(f3, rs1, rs2, 13'((tgt - i) * 4));
                    landing[tgt] = 1'b1;
                end
                8: begin
                    mem[i] = encJ(rd, 21'((tgt - i) * 4));
                    landing[tgt] = 1'b1;
                end
                default: begin
                    // no earlier jump may skip the x30 setup
                    if (i < 58 && !landing[i + 1]) begin
                        // jalr through x30 loaded just before
                        tgt = i + 2 + rnd(4);
                        if (tgt > 60) tgt = 60;
                        mem[i] = encI(`RV_OP_OP_IMM, 3'b000, 5'd30, 5'd0, 12'(tgt * 4));
                        mem[i + 1] = encI(`RV_OP_JALR, 3'b000, rd, 5'd30, 12'h0);
                        landing[tgt] = 1'b1;
                        i++;
                    end else begin
                        mem[i] = encI(`RV_OP_OP_IMM, 3'b000, rd, rs1, 12'h0);
                    end
                end
            endcase
            i++;
        end
        mem[60] = 32'h0;
    endtask

    task automatic serveBus();
        logic [7:0] idx;
        idx = wbAdr[9:2];
        if (wbWe) begin
            for (int b = 0; b < 4; b++)
                if (wbSel[b]) mem[idx][8 * b +: 8] = wbDatW[8 * b +: 8];
        end
        wbDatR = mem[idx];
    endtask

    // memory slave acks after 0 to 3 wait cycles
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (rst || wbAck) begin
                wbAck = 1'b0;
                busy = 1'b0;
            end else if (wbCyc && wbStb) begin
                if (!busy) begin
                    busy = 1'b1;
                    waitLeft = rnd(4);
                end
                if (waitLeft == 0) begin
                    serveBus();
                    wbAck = 1'b1;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    task automatic compareRetire();
        rvPkg::retireT expRec;
        if (expQ.size() == 0) begin
            abortRun("the core retired more instructions than the model");
        end else begin
            expRec = expQ.pop_front();
            checkValue("retire.pc", retire.pc, expRec.pc);
            checkValue("retire.rd", retire.rd, expRec.rd);
            checkValue("retire.value", retire.value, expRec.value);
            checkValue("retire.regWrite", retire.regWrite, expRec.regWrite);
            retired++;
        end
    endtask

    // mid-cycle monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (u_dut.uSva.failCount != 0)
                abortRun("a bus or retire assertion failed");
            if (sawHalt && (retireValid || wbCyc))
                abortRun("the core kept running after the halt");
            if (halted) sawHalt = 1'b1;
            if (retireValid) compareRetire();
        end
    end

    initial begin : mainFlow
        int expCount;
        int cycles;
        seed = 32'h19144330;
        rst = 1'b1;
        wbAck = 1'b0;
        wbDatR = 32'h0;
        busy = 1'b0;
        sawHalt = 1'b0;
        waitLeft = 0;
        retired = 0;
        buildProgram();
        runModel();
        expCount = expQ.size();
        repeat (8) begin
            @(posedge clk);
            #1;
            checkValue("wbCyc", wbCyc, 1'b0);
            checkValue("retireValid", retireValid, 1'b0);
            checkValue("halted", halted, 1'b0);
        end
        rst = 1'b0;
        // first fetch is on the bus by mid-cycle
        @(negedge clk);
        checkValue("wbCyc", wbCyc, 1'b1);
        checkValue("wbAdr", wbAdr, `RV_RESET_PC);
        checkValue("wbWe", wbWe, 1'b0);
        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 5000) abortRun("timeout waiting for halted");
        end
        // quiet period after the halt
        repeat (20) @(negedge clk);
        if (u_dut.uSva.failCount != 0)
            abortRun("a bus or retire assertion failed");
        checkValue("retire count", retired, expCount);
        checkValue("halted", halted, 1'b1);
        for (int a = 0; a < 256; a++)
            checkValue($sformatf("mem[%0d]", a), mem[a], refMem[a]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_core_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_sva (
    input logic        clk,
    input logic        rst,
    input logic        wbCyc,
    input logic        wbStb,
    input logic        wbAck,
    input logic [31:0] wbAdr,
    input logic        retireValid,
    input logic        halted
);

    int failCount = 0;

    stbHeld: assert property (@(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> wbStb)
    else begin
        failCount++;
        $error("wishbone stb dropped before ack");
    end

    adrStable: assert property (@(posedge clk) disable iff (rst)
        (wbStb && !wbAck) |=> $stable(wbAdr))
    else begin
        failCount++;
        $error("wishbone address changed while waiting for ack");
    end

    retirePulse: assert property (@(posedge clk) disable iff (rst)
        retireValid |=> !retireValid)
    else begin
        failCount++;
        $error("retireValid held longer than one cycle");
    end

    // halt is final, the bus stays idle
    haltSticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> (halted && !wbCyc))
    else begin
        failCount++;
        $error("core left the halted state or started a bus cycle");
    end

endmodule

bind rv_core rv_core_sva uSva (.*);

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rv_core (
    input  logic          clk,
    input  logic          rst,
    output logic          wbCyc,
    output logic          wbStb,
    output logic          wbWe,
    output logic [31:0]   wbAdr,
    output logic [31:0]   wbDatW,
    output logic [3:0]    wbSel,
    input  logic [31:0]   wbDatR,
    input  logic          wbAck,
    output logic          retireValid,
    output rvPkg::retireT retire,
    output logic          halted
);

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB} stateT;

    stateT          state;
    logic [31:0]    pc, inst, loadWord;
    logic [31:0]    storeWord, wbData;
    logic [3:0]     storeSel;
    logic           decHalt, rfWe, memAccess;
    rvPkg::decodedT dec;
    rvPkg::execT    ex, exReg;
    rvPkg::wbReqT   wbReq;

    assign rfWe      = (state == WB) && exReg.ctrl.regWrite;
    assign memAccess = ex.ctrl.load | ex.ctrl.memWrite;

    rv_decode uDecode (
        .clk   (clk),
        .rst   (rst),
        .inst  (inst),
        .pc    (pc),
        .wbWe  (rfWe),
        .wbRd  (exReg.rd),
        .wbData(wbData),
        .dec   (dec),
        .halt  (decHalt)
    );

    rv_execute uExecute (
        .dec(dec),
        .ex (ex)
    );

    rv_result uResult (
        .ex       (exReg),
        .loadWord (loadWord),
        .storeWord(storeWord),
        .storeSel (storeSel),
        .wbData   (wbData),
        .ret      (retire)
    );

    // the zero word parks the sequencer in DECODE
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                FETCH:   if (wbAck) state <= DECODE;
                DECODE:  if (!decHalt) state <= EXEC;
                EXEC:    state <= memAccess ? MEM : WB;
                MEM:     if (wbAck) state <= WB;
                WB: begin
                    pc    <= exReg.nextPc;
                    state <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && wbAck)
            inst <= wbDatR;
        if (state == EXEC)
            exReg <= ex;
        if (state == MEM && wbAck)
            loadWord <= wbDatR;
    end

    // bus request is held steady by the state and registered operands
    always_comb begin
        wbReq.cyc  = !rst && ((state == FETCH) || (state == MEM));
        wbReq.we   = (state == MEM) && exReg.ctrl.memWrite;
        wbReq.adr  = (state == MEM) ? {exReg.aluOut[31:2], 2'b00} : pc;
        wbReq.datW = storeWord;
        wbReq.sel  = wbReq.we ? storeSel : 4'b1111;
    end

    assign wbCyc  = wbReq.cyc;
    assign wbStb  = wbReq.cyc;
    assign wbWe   = wbReq.we;
    assign wbAdr  = wbReq.adr;
    assign wbDatW = wbReq.datW;
    assign wbSel  = wbReq.sel;

    assign retireValid = (state == WB);
    assign halted      = (state == DECODE) && decHalt;

endmodule

`default_nettype wire

// ==== verilog/rv_result.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rv_result (
    input  rvPkg::execT    ex,
    input  logic [31:0]    loadWord,
    output logic [31:0]    storeWord,
    output logic [3:0]     storeSel,
    output logic [31:0]    wbData,
    output rvPkg::retireT  ret
);

    logic [31:0] shifted, loadVal;

    // replicate store data, sel picks the lanes
    always_comb begin
        case (ex.funct3)
            `RV_F3_B: begin
                storeWord = {4{ex.storeData[7:0]}};
                storeSel  = 4'b0001 << ex.aluOut[1:0];
            end
            `RV_F3_H: begin
                storeWord = {2{ex.storeData[15:0]}};
                storeSel  = ex.aluOut[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                storeWord = ex.storeData;
                storeSel  = 4'b1111;
            end
        endcase
    end

    assign shifted = loadWord >> {ex.aluOut[1:0], 3'b000};

    always_comb begin
        case (ex.funct3)
            `RV_F3_B:  loadVal = {{24{shifted[7]}}, shifted[7:0]};
            `RV_F3_H:  loadVal = {{16{shifted[15]}}, shifted[15:0]};
            `RV_F3_BU: loadVal = {24'h0, shifted[7:0]};
            `RV_F3_HU: loadVal = {16'h0, shifted[15:0]};
            default:   loadVal = loadWord;
        endcase
    end

    assign wbData = ex.ctrl.load ? loadVal : ex.aluOut;

    // no destination shown for stores and branches
    always_comb begin
        ret.pc       = ex.pc;
        ret.rd       = ex.ctrl.regWrite ? ex.rd : 5'd0;
        ret.value    = ex.ctrl.regWrite ? wbData : 32'h0;
        ret.regWrite = ex.ctrl.regWrite;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rv_execute (
    input  rvPkg::decodedT dec,
    output rvPkg::execT    ex
);

    logic [31:0] opA, opB, aluOut;
    logic [31:0] pcPlus4, pcTarget, jalrTarget;
    logic        taken;

    assign opA = dec.ctrl.aluASrc ? dec.pc : dec.rs1Val;

    always_comb begin
        case (dec.ctrl.aluBSrc)
            2'b00:   opB = dec.rs2Val;
            2'b01:   opB = dec.imm;
            default: opB = 32'd4;
        endcase
    end

    always_comb begin
        case (dec.ctrl.aluSel)
            `RV_ALU_SUB:  aluOut = opA - opB;
            `RV_ALU_SLL:  aluOut = opA << opB[4:0];
            `RV_ALU_SLT:  aluOut = {31'h0, $signed(opA) < $signed(opB)};
            `RV_ALU_SLTU: aluOut = {31'h0, opA < opB};
            `RV_ALU_XOR:  aluOut = opA ^ opB;
            `RV_ALU_SRL:  aluOut = opA >> opB[4:0];
            `RV_ALU_SRA:  aluOut = $signed(opA) >>> opB[4:0];
            `RV_ALU_OR:   aluOut = opA | opB;
            `RV_ALU_AND:  aluOut = opA & opB;
            default:      aluOut = opA + opB;
        endcase
    end

    // branch outcome from the sub/slt result on rs1, rs2
    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  taken = (aluOut == 32'h0);
            `RV_F3_BNE:  taken = (aluOut != 32'h0);
            `RV_F3_BLT,
            `RV_F3_BLTU: taken = aluOut[0];
            `RV_F3_BGE,
            `RV_F3_BGEU: taken = !aluOut[0];
            default:     taken = 1'b0;
        endcase
    end

    assign pcPlus4    = dec.pc + 32'd4;
    assign pcTarget   = dec.pc + dec.imm;
    assign jalrTarget = (dec.rs1Val + dec.imm) & ~32'd1;

    always_comb begin
        ex.pc        = dec.pc;
        ex.aluOut    = aluOut;
        ex.storeData = dec.rs2Val;
        ex.rd        = dec.rd;
        ex.funct3    = dec.funct3;
        ex.ctrl      = dec.ctrl;
        if (dec.ctrl.jump)
            ex.nextPc = (dec.ctrl.immKind == `RV_IMM_J) ? pcTarget : jalrTarget;
        else if (dec.ctrl.branch && taken)
            ex.nextPc = pcTarget;
        else
            ex.nextPc = pcPlus4;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rv_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic [31:0]    inst,
    input  logic [31:0]    pc,
    input  logic           wbWe,
    input  logic [4:0]     wbRd,
    input  logic [31:0]    wbData,
    output rvPkg::decodedT dec,
    output logic           halt
);

    rvPkg::ctrlT ctrl;
    logic [4:0]  rs1Addr;
    logic [31:0] rs1Val, rs2Val, imm;

    rv_control_unit uCtrl (
        .opcode  (inst[6:0]),
        .funct3  (inst[14:12]),
        .funct7b5(inst[30]),
        .ctrl    (ctrl)
    );

    // lui adds its immediate to x0, its rs1 field is immediate bits
    assign rs1Addr = (inst[6:0] == `RV_OP_LUI) ? 5'd0 : inst[19:15];

    rv_reg_file uRegs (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rs1Addr),
        .rs2   (inst[24:20]),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .we    (wbWe),
        .rd    (wbRd),
        .wdata (wbData)
    );

    always_comb begin
        case (ctrl.immKind)
            `RV_IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            `RV_IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            `RV_IMM_U: imm = {inst[31:12], 12'h0};
            `RV_IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:   imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        dec.pc     = pc;
        dec.rs1Val = rs1Val;
        dec.rs2Val = rs2Val;
        dec.imm    = imm;
        dec.rd     = inst[11:7];
        dec.funct3 = inst[14:12];
        dec.ctrl   = ctrl;
    end

    assign halt = (inst == 32'h0);

endmodule

`default_nettype wire

// ==== verilog/rv_reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1Val,
    output logic [31:0] rs2Val,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rs1Val = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
    assign rs2Val = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/rv_control_unit.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"
`default_nettype none

module rv_control_unit (
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic        funct7b5,
    output rvPkg::ctrlT ctrl
);

    logic isOp, isOpImm, isLoad, isStore, isBranch;
    logic isJal, isJalr, isLui, isAuipc;
    logic [3:0] riSel, brSel;

    // opcode classes, all in parallel
    assign isOp     = (opcode == `RV_OP_OP);
    assign isOpImm  = (opcode == `RV_OP_OP_IMM);
    assign isLoad   = (opcode == `RV_OP_LOAD);
    assign isStore  = (opcode == `RV_OP_STORE);
    assign isBranch = (opcode == `RV_OP_BRANCH);
    assign isJal    = (opcode == `RV_OP_JAL);
    assign isJalr   = (opcode == `RV_OP_JALR);
    assign isLui    = (opcode == `RV_OP_LUI);
    assign isAuipc  = (opcode == `RV_OP_AUIPC);

    // register/immediate alu ops
    always_comb begin
        case (funct3)
            3'b000:  riSel = (isOp && funct7b5) ? `RV_ALU_SUB : `RV_ALU_ADD;
            3'b001:  riSel = `RV_ALU_SLL;
            3'b010:  riSel = `RV_ALU_SLT;
            3'b011:  riSel = `RV_ALU_SLTU;
            3'b100:  riSel = `RV_ALU_XOR;
            3'b101:  riSel = funct7b5 ? `RV_ALU_SRA : `RV_ALU_SRL;
            3'b110:  riSel = `RV_ALU_OR;
            default: riSel = `RV_ALU_AND;
        endcase
    end

    // unsigned compares for bltu/bgeu, signed for blt/bge, else eq/ne
    assign brSel = (funct3[2] & funct3[1]) ? `RV_ALU_SLTU :
                   (funct3[2] ^ funct3[1]) ? `RV_ALU_SLT  : `RV_ALU_SUB;

    always_comb begin
        if (isOpImm || isJalr || isLoad)
            ctrl.immKind = `RV_IMM_I;
        else if (isLui || isAuipc)
            ctrl.immKind = `RV_IMM_U;
        else if (isBranch)
            ctrl.immKind = `RV_IMM_B;
        else if (isStore)
            ctrl.immKind = `RV_IMM_S;
        else if (isJal)
            ctrl.immKind = `RV_IMM_J;
        else
            ctrl.immKind = `RV_IMM_I;

        ctrl.regWrite   = isOp | isOpImm | isLoad | isJal | isJalr | isLui | isAuipc;
        ctrl.memWrite   = isStore;
        ctrl.branch     = isBranch;
        ctrl.jump       = isJal | isJalr;
        ctrl.load       = isLoad;
        ctrl.aluASrc    = isAuipc | isJal | isJalr;
        ctrl.aluBSrc[0] = isOpImm | isLoad | isStore | isLui | isAuipc;
        // jumps compute the link value pc + 4
        ctrl.aluBSrc[1] = isJal | isJalr;

        if (isBranch)
            ctrl.aluSel = brSel;
        else if (isOp || isOpImm)
            ctrl.aluSel = riSel;
        else
            ctrl.aluSel = `RV_ALU_ADD;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rvPkg;

    typedef struct packed {
        logic [2:0] immKind;
        logic       regWrite;
        logic       memWrite;
        logic       branch;
        logic       jump;
        logic       load;
        logic       aluASrc;   // 0 rs1, 1 pc
        logic [1:0] aluBSrc;   // 00 rs2, 01 imm, 1x constant 4
        logic [3:0] aluSel;
    } ctrlT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        ctrlT        ctrl;
    } decodedT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] nextPc;
        logic [31:0] storeData;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        ctrlT        ctrl;
    } execT;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        regWrite;
    } retireT;

    // wishbone master request
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [31:0] adr;
        logic [31:0] datW;
        logic [3:0]  sel;
    } wbReqT;

endpackage

`default_nettype wire

// ==== verilog/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// major opcodes
`define RV_OP_OP        7'b0110011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111

// load/store widths
`define RV_F3_B         3'b000
`define RV_F3_H         3'b001
`define RV_F3_W         3'b010
`define RV_F3_BU        3'b100
`define RV_F3_HU        3'b101

// branch conditions
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

`define RV_ALU_ADD      4'd0
`define RV_ALU_SUB      4'd1
`define RV_ALU_SLL      4'd2
`define RV_ALU_SLT      4'd3
`define RV_ALU_SLTU     4'd4
`define RV_ALU_XOR      4'd5
`define RV_ALU_SRL      4'd6
`define RV_ALU_SRA      4'd7
`define RV_ALU_OR       4'd8
`define RV_ALU_AND      4'd9

`define RV_IMM_I        3'd0
`define RV_IMM_S        3'd1
`define RV_IMM_B        3'd2
`define RV_IMM_U        3'd3
`define RV_IMM_J        3'd4

`define RV_RESET_PC     32'h0000_0000

`endif
